/* source/decoder_params.svh */
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// Fetch bundle widths
`define ADDRESS_WIDTH   64  // Instruction address
`define INST_WIDTH      32  // Fixed POWER word
`define PID_WIDTH       20  // Process ID
`define TID_WIDTH       16  // Thread ID
`define MAJ_ID_WIDTH    64  // Program order tag

// Decode widths
`define OPCODE_WIDTH    12  // Internal opcode
`define REG_FIELD_WIDTH 5   // RT, RA, RB, RC fields
`define XO_WIDTH        5   // A-form extended opcode
`define BODY_WIDTH      21  // Bits 6..25 plus Rc

// Primary opcodes of the A-form groups
`define PRIM_FIXED        6'd31
`define PRIM_FLOAT_DOUBLE 6'd63
`define PRIM_FLOAT_SINGLE 6'd59

`endif

/* source/decodePkg.sv */
`include "decoder_params.svh"

package decodePkg;

    // Bit 1 read, bit 0 write
    typedef enum logic [1:0] {
        NONE  = 2'b00,
        WRITE = 2'b01,
        READ  = 2'b10
    } accessPattern_t;

    typedef enum logic [2:0] {
        FX = 3'd0,  // Integer
        FP = 3'd1,  // Floating point
        VX = 3'd2,  // Vector
        CR = 3'd3,  // Condition register
        LS = 3'd4   // Load/store
    } funcUnit_t;

    // Which source operands an instruction reads
    typedef enum logic [2:0] {
        SEL_INT,    // RA may be zero, RB read
        SRC_AB,
        SRC_AC,
        SRC_B,
        SRC_ABC
    } operandClass_t;

    typedef struct packed {
        logic           isReg;
        accessPattern_t access;
    } operandUse_t;

    // Instruction word keeps ISA numbering, bit 0 is the MSB
    typedef struct packed {
        logic [0:`INST_WIDTH-1]     inst;
        logic [`ADDRESS_WIDTH-1:0] address;
        logic [`PID_WIDTH-1:0]     pid;
        logic [`TID_WIDTH-1:0]     tid;
        logic [`MAJ_ID_WIDTH-1:0]  majId;
    } fetchBundle_t;

    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]  opcode;
        funcUnit_t                 unit;
        logic [`MAJ_ID_WIDTH-1:0]  majId;
        logic [`ADDRESS_WIDTH-1:0] address;
        logic [`PID_WIDTH-1:0]     pid;
        logic [`TID_WIDTH-1:0]     tid;
        operandUse_t               rt;
        operandUse_t               ra;
        operandUse_t               rb;
        operandUse_t               rc;
        logic [0:`BODY_WIDTH-1]    body;  // Register fields then Rc
    } decodedInst_t;

endpackage

/* source/stageRegister.sv */
`timescale 1ns/1ps

module stageRegister #(
    parameter type payload_t = logic
) (
    input  logic     clock_i,
    input  logic     rst_i,
    input  logic     enable_i,
    input  logic     stall_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // Valid bit follows enable unless frozen
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= enable_i;
        end
    end

    // Payload is only meaningful while valid_o is high
    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* source/opcodeDecoder.sv */
`timescale 1ns/1ps
`include "decoder_params.svh"

module opcodeDecoder
    import decodePkg::*;
(
    input  logic [5:0]               primary_i,
    input  logic [`XO_WIDTH-1:0]     xo_i,
    output logic [`OPCODE_WIDTH-1:0] opcode_o,
    output funcUnit_t                unit_o,
    output operandClass_t            class_o,
    output logic                     valid_o
);

    // A-form extended opcodes
    localparam logic [`XO_WIDTH-1:0] XO_ISEL    = 5'd15;
    localparam logic [`XO_WIDTH-1:0] XO_FDIV    = 5'd18;
    localparam logic [`XO_WIDTH-1:0] XO_FSUB    = 5'd20;
    localparam logic [`XO_WIDTH-1:0] XO_FADD    = 5'd21;
    localparam logic [`XO_WIDTH-1:0] XO_FSQRT   = 5'd22;
    localparam logic [`XO_WIDTH-1:0] XO_FSEL    = 5'd23;
    localparam logic [`XO_WIDTH-1:0] XO_FRE     = 5'd24;
    localparam logic [`XO_WIDTH-1:0] XO_FMUL    = 5'd25;
    localparam logic [`XO_WIDTH-1:0] XO_FRSQRTE = 5'd26;
    localparam logic [`XO_WIDTH-1:0] XO_FMSUB   = 5'd28;
    localparam logic [`XO_WIDTH-1:0] XO_FMADD   = 5'd29;
    localparam logic [`XO_WIDTH-1:0] XO_FNMSUB  = 5'd30;
    localparam logic [`XO_WIDTH-1:0] XO_FNMADD  = 5'd31;

    // Single opcodes sit 12 above their double twins
    localparam logic [`OPCODE_WIDTH-1:0] SINGLE_OFFSET = 12'd12;

    logic [`OPCODE_WIDTH-1:0] fpOpcode;
    operandClass_t            fpClass;
    logic                     fpKnown;

    // Floating XO table in double-precision numbering
    always_comb begin
        fpOpcode = '0;
        fpClass  = SRC_AB;
        fpKnown  = 1'b1;
        case (xo_i)
            XO_FADD:    begin fpOpcode = 12'd2;  fpClass = SRC_AB;  end
            XO_FSUB:    begin fpOpcode = 12'd3;  fpClass = SRC_AB;  end
            XO_FMUL:    begin fpOpcode = 12'd4;  fpClass = SRC_AC;  end
            XO_FDIV:    begin fpOpcode = 12'd5;  fpClass = SRC_AB;  end
            XO_FSQRT:   begin fpOpcode = 12'd6;  fpClass = SRC_B;   end
            XO_FRE:     begin fpOpcode = 12'd7;  fpClass = SRC_B;   end
            XO_FRSQRTE: begin fpOpcode = 12'd8;  fpClass = SRC_B;   end
            XO_FMADD:   begin fpOpcode = 12'd9;  fpClass = SRC_ABC; end
            XO_FMSUB:   begin fpOpcode = 12'd10; fpClass = SRC_ABC; end
            XO_FNMADD:  begin fpOpcode = 12'd11; fpClass = SRC_ABC; end
            XO_FNMSUB:  begin fpOpcode = 12'd12; fpClass = SRC_ABC; end
            XO_FSEL:    begin fpOpcode = 12'd13; fpClass = SRC_ABC; end
            default:    fpKnown = 1'b0;
        endcase
    end

    always_comb begin
        opcode_o = '0;
        unit_o   = FX;
        class_o  = SRC_AB;
        valid_o  = 1'b0;
        case (primary_i)
            `PRIM_FIXED: begin
                if (xo_i == XO_ISEL) begin  // Integer select
                    opcode_o = 12'd1;
                    unit_o   = CR;
                    class_o  = SEL_INT;
                    valid_o  = 1'b1;
                end
            end
            `PRIM_FLOAT_DOUBLE: begin
                opcode_o = fpOpcode;
                unit_o   = FP;
                class_o  = fpClass;
                valid_o  = fpKnown;
            end
            `PRIM_FLOAT_SINGLE: begin
                if (fpKnown && xo_i != XO_FSEL) begin  // No single-precision select
                    opcode_o = fpOpcode + SINGLE_OFFSET;
                    unit_o   = FP;
                    class_o  = fpClass;
                    valid_o  = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* source/operandClassifier.sv */
`timescale 1ns/1ps
`include "decoder_params.svh"

module operandClassifier
    import decodePkg::*;
(
    input  operandClass_t               class_i,
    input  logic [`REG_FIELD_WIDTH-1:0] raField_i,
    output operandUse_t                 rt_o,
    output operandUse_t                 ra_o,
    output operandUse_t                 rb_o,
    output operandUse_t                 rc_o
);

    localparam operandUse_t USE_WRITE = '{isReg: 1'b1, access: WRITE};
    localparam operandUse_t USE_READ  = '{isReg: 1'b1, access: READ};
    localparam operandUse_t USE_NONE  = '{isReg: 1'b0, access: NONE};

    always_comb begin
        rt_o = USE_WRITE;  // Every A-form writes RT
        ra_o = USE_NONE;
        rb_o = USE_NONE;
        rc_o = USE_NONE;
        case (class_i)
            SEL_INT: begin
                // RA of zero selects the constant 0, still read
                ra_o = '{isReg: (raField_i != '0), access: READ};
                rb_o = USE_READ;
            end
            SRC_AB: begin
                ra_o = USE_READ;
                rb_o = USE_READ;
            end
            SRC_AC: begin
                ra_o = USE_READ;
                rc_o = USE_READ;
            end
            SRC_B: begin
                rb_o = USE_READ;
            end
            SRC_ABC: begin
                ra_o = USE_READ;
                rb_o = USE_READ;
                rc_o = USE_READ;
            end
            default: ;
        endcase
    end

endmodule

/* source/aFormDecoder.sv */
`timescale 1ns/1ps
`include "decoder_params.svh"

module aFormDecoder
    import decodePkg::*;
(
    input  logic         clock_i,
    input  logic         rst_i,
    input  logic         enable_i,
    input  logic         stall_i,
    input  fetchBundle_t inst_i,
    output logic         enable_o,
    output decodedInst_t decoded_o
);

    fetchBundle_t                fetched;
    logic                        fetchValid;
    logic [5:0]                  primary;
    logic [`XO_WIDTH-1:0]        xo;
    logic [`REG_FIELD_WIDTH-1:0] raField;
    logic                        opValid;
    operandClass_t               opClass;
    decodedInst_t                decodeNext;

    stageRegister #(.payload_t(fetchBundle_t)) u_inStage (
        .clock_i  (clock_i),
        .rst_i    (rst_i),
        .enable_i (enable_i),
        .stall_i  (stall_i),
        .data_i   (inst_i),
        .valid_o  (fetchValid),
        .data_o   (fetched)
    );

    // ISA bit numbering, bit 0 is the MSB
    assign primary = fetched.inst[0:5];
    assign raField = fetched.inst[11:15];
    assign xo      = fetched.inst[26:30];

    opcodeDecoder u_opcodeDecoder (
        .primary_i (primary),
        .xo_i      (xo),
        .opcode_o  (decodeNext.opcode),
        .unit_o    (decodeNext.unit),
        .class_o   (opClass),
        .valid_o   (opValid)
    );

    operandClassifier u_operandClassifier (
        .class_i   (opClass),
        .raField_i (raField),
        .rt_o      (decodeNext.rt),
        .ra_o      (decodeNext.ra),
        .rb_o      (decodeNext.rb),
        .rc_o      (decodeNext.rc)
    );

    assign decodeNext.majId   = fetched.majId;
    assign decodeNext.address = fetched.address;
    assign decodeNext.pid     = fetched.pid;
    assign decodeNext.tid     = fetched.tid;
    assign decodeNext.body    = {fetched.inst[6:25], fetched.inst[31]};  // Fields plus Rc

    // Invalid words drop out here as a bubble
    stageRegister #(.payload_t(decodedInst_t)) u_outStage (
        .clock_i  (clock_i),
        .rst_i    (rst_i),
        .enable_i (fetchValid & opValid),
        .stall_i  (stall_i),
        .data_i   (decodeNext),
        .valid_o  (enable_o),
        .data_o   (decoded_o)
    );

endmodule

/* testbench/tbAFormDecoder.sv */
`timescale 1ns/1ps
`include "decoder_params.svh"

module tbAFormDecoder
    import decodePkg::*;
();

    localparam int CLOCK_PERIOD    = 40;
    localparam int PLANNED_INSTS   = 80;   // Sum of the instructions issued below
    localparam int CYCLES_PER_INST = 10;
    localparam int MARGIN_CYCLES   = 200;

    localparam logic [4:0] FP_XOS [12] = '{5'd18, 5'd20, 5'd21, 5'd22, 5'd23, 5'd24,
                                           5'd25, 5'd26, 5'd28, 5'd29, 5'd30, 5'd31};

    logic         clock_i  = 1'b0;
    logic         rst_i    = 1'b1;
    logic         enable_i = 1'b0;
    logic         stall_i  = 1'b0;
    fetchBundle_t inst_i   = '0;
    logic         enable_o;
    decodedInst_t decoded_o;

    logic         stallRandom = 1'b0;  // Turns the stall generator on
    decodedInst_t expectedQ[$];
    logic         prevStall   = 1'b0;
    logic         prevEnable  = 1'b0;
    decodedInst_t prevDecoded = '0;

    aFormDecoder u_dut (
        .clock_i   (clock_i),
        .rst_i     (rst_i),
        .enable_i  (enable_i),
        .stall_i   (stall_i),
        .inst_i    (inst_i),
        .enable_o  (enable_o),
        .decoded_o (decoded_o)
    );

    initial begin
        forever #(CLOCK_PERIOD / 2) clock_i = ~clock_i;
    end

    task automatic failRun();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic raiseError(input string msg);
        $display("%s", msg);
        failRun();
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
            failRun();
        end
    endtask

    task automatic checkUnit(input string name, input funcUnit_t actual,
                             input funcUnit_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
            failRun();
        end
    endtask

    task automatic checkOperand(input string name, input operandUse_t actual,
                                input operandUse_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
            failRun();
        end
    endtask

    task automatic checkDecoded(input string name, input decodedInst_t actual,
                                input decodedInst_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
            failRun();
        end
    endtask

    // Internal opcode from the ISA encoding, 0 for anything not decoded
    function automatic int expectedOpcode(input logic [5:0] primary, input logic [4:0] xo);
        int code;
        code = 0;
        if (primary == `PRIM_FIXED && xo == 5'd15) begin
            code = 1;
        end else if (primary == `PRIM_FLOAT_DOUBLE) begin
            case (xo)
                5'd21: code = 2;
                5'd20: code = 3;
                5'd25: code = 4;
                5'd18: code = 5;
                5'd22: code = 6;
                5'd24: code = 7;
                5'd26: code = 8;
                5'd29: code = 9;
                5'd28: code = 10;
                5'd31: code = 11;
                5'd30: code = 12;
                5'd23: code = 13;
                default: code = 0;
            endcase
        end else if (primary == `PRIM_FLOAT_SINGLE) begin
            case (xo)
                5'd21: code = 14;
                5'd20: code = 15;
                5'd25: code = 16;
                5'd18: code = 17;
                5'd22: code = 18;
                5'd24: code = 19;
                5'd26: code = 20;
                5'd29: code = 21;
                5'd28: code = 22;
                5'd31: code = 23;
                5'd30: code = 24;
                default: code = 0;
            endcase
        end
        return code;
    endfunction

    function automatic bit predictDecode(input fetchBundle_t bundle,
                                         output decodedInst_t expected);
        int         code;
        bit         readA;
        bit         readB;
        bit         readC;
        logic [4:0] raField;
        code    = expectedOpcode(bundle.inst[0:5], bundle.inst[26:30]);
        raField = bundle.inst[11:15];
        readA   = 1'b1;
        readB   = 1'b1;
        readC   = 1'b1;
        case (code)
            1, 2, 3, 5, 14, 15, 17: readC = 1'b0;
            4, 16: readB = 1'b0;
            6, 7, 8, 18, 19, 20: begin
                readA = 1'b0;
                readC = 1'b0;
            end
            default: ;
        endcase
        expected.opcode       = code[`OPCODE_WIDTH-1:0];
        expected.unit         = (code == 1) ? CR : FP;
        expected.majId        = bundle.majId;
        expected.address      = bundle.address;
        expected.pid          = bundle.pid;
        expected.tid          = bundle.tid;
        expected.rt.isReg     = 1'b1;
        expected.rt.access    = WRITE;
        expected.ra.isReg     = readA && (code != 1 || raField != 5'd0);  // isel RA of 0
        expected.ra.access    = readA ? READ : NONE;
        expected.rb.isReg     = readB;
        expected.rb.access    = readB ? READ : NONE;
        expected.rc.isReg     = readC;
        expected.rc.access    = readC ? READ : NONE;
        expected.body         = {20'(bundle.inst >> 6), 1'(bundle.inst)};  // Four fields, Rc
        return code != 0;
    endfunction

    // Negative raValue picks a random RA field
    function automatic fetchBundle_t makeBundle(input logic [5:0] primary, input logic [4:0] xo,
                                                input int raValue);
        fetchBundle_t bundle;
        logic [4:0]   raField;
        raField        = (raValue < 0) ? 5'($urandom) : 5'(raValue);
        bundle.inst    = {primary, 5'($urandom), raField, 5'($urandom), 5'($urandom), xo,
                          1'($urandom)};
        bundle.address = {$urandom, $urandom};
        bundle.pid     = 20'($urandom);
        bundle.tid     = 16'($urandom);
        bundle.majId   = {$urandom, $urandom};
        return bundle;
    endfunction

    // Returns on the edge that accepts the bundle
    task automatic issue(input fetchBundle_t bundle);
        decodedInst_t expected;
        enable_i <= 1'b1;
        inst_i   <= bundle;
        do begin
            @(posedge clock_i);
        end while (stall_i);
        if (predictDecode(bundle, expected)) begin
            expectedQ.push_back(expected);
        end
    endtask

    task automatic waitDrained(input int maxCycles);
        int cycles;
        cycles   = 0;
        enable_i <= 1'b0;
        while (expectedQ.size() != 0 && cycles < maxCycles) begin
            @(posedge clock_i);
            cycles++;
        end
        if (expectedQ.size() != 0) begin
            raiseError("decoded instructions did not come out in time");
        end else begin
            repeat (3) @(posedge clock_i);  // Room for a stray output
        end
    endtask

    always @(posedge clock_i) begin
        if (stallRandom) begin
            stall_i <= ($urandom_range(0, 3) == 0);
        end else begin
            stall_i <= 1'b0;
        end
    end

    // Output is consumed at an edge with stall_i low
    always @(negedge clock_i) begin
        decodedInst_t expected;
        if (!rst_i) begin
            if (prevStall) begin
                checkFlag("enable_o (stall hold)", enable_o, prevEnable);
                checkDecoded("decoded_o (stall hold)", decoded_o, prevDecoded);
            end
            if (enable_o && !stall_i) begin
                if (expectedQ.size() == 0) begin
                    raiseError("enable_o was high with no instruction expected");
                end else begin
                    expected = expectedQ.pop_front();
                    checkUnit("decoded_o.unit", decoded_o.unit, expected.unit);
                    checkOperand("decoded_o.rt", decoded_o.rt, expected.rt);
                    checkOperand("decoded_o.ra", decoded_o.ra, expected.ra);
                    checkOperand("decoded_o.rb", decoded_o.rb, expected.rb);
                    checkOperand("decoded_o.rc", decoded_o.rc, expected.rc);
                    checkDecoded("decoded_o", decoded_o, expected);
                end
            end
        end
        prevStall   = stall_i;
        prevEnable  = enable_o;
        prevDecoded = decoded_o;
    end

    task automatic testLatency();
        @(negedge clock_i);
        checkFlag("enable_o", enable_o, 1'b0);  // Idle after reset
        @(posedge clock_i);
        issue(makeBundle(`PRIM_FLOAT_DOUBLE, 5'd21, -1));
        enable_i <= 1'b0;
        @(negedge clock_i);
        checkFlag("enable_o", enable_o, 1'b0);  // Still in the input stage
        @(negedge clock_i);
        checkFlag("enable_o", enable_o, 1'b1);
        waitDrained(8);
    endtask

    task automatic testFloat(input logic [5:0] primary);
        foreach (FP_XOS[i]) begin
            if (primary == `PRIM_FLOAT_DOUBLE || FP_XOS[i] != 5'd23) begin
                issue(makeBundle(primary, FP_XOS[i], -1));
            end
        end
        if (primary == `PRIM_FLOAT_SINGLE) begin
            issue(makeBundle(primary, 5'd23, -1));  // No single select
        end
        waitDrained(20);
    endtask

    task automatic testIntSelect();
        issue(makeBundle(`PRIM_FIXED, 5'd15, 0));
        issue(makeBundle(`PRIM_FIXED, 5'd15, 1 + $urandom_range(0, 30)));
        issue(makeBundle(`PRIM_FIXED, 5'd15, 0));
        issue(makeBundle(`PRIM_FIXED, 5'd15, 31));
        waitDrained(12);
    endtask

    task automatic testInvalid();
        issue(makeBundle(6'd0, 5'd21, -1));
        issue(makeBundle(`PRIM_FLOAT_DOUBLE, 5'd21, -1));
        issue(makeBundle(6'd14, 5'd15, -1));
        issue(makeBundle(`PRIM_FIXED, 5'd16, -1));
        issue(makeBundle(`PRIM_FLOAT_SINGLE, 5'd29, -1));
        issue(makeBundle(`PRIM_FLOAT_DOUBLE, 5'd19, -1));
        issue(makeBundle(`PRIM_FLOAT_SINGLE, 5'd27, -1));
        issue(makeBundle(`PRIM_FIXED, 5'd15, -1));
        issue(makeBundle(6'd62, 5'd23, -1));
        issue(makeBundle(`PRIM_FLOAT_DOUBLE, 5'd0, -1));
        issue(makeBundle(`PRIM_FLOAT_SINGLE, 5'd18, -1));
        waitDrained(20);
    endtask

    function automatic logic [5:0] randomPrimary();
        case ($urandom_range(0, 2))
            0: return `PRIM_FIXED;
            1: return `PRIM_FLOAT_SINGLE;
            default: return `PRIM_FLOAT_DOUBLE;
        endcase
    endfunction

    task automatic testStall();
        stallRandom <= 1'b1;
        repeat (40) begin
            issue(makeBundle(randomPrimary(), 5'($urandom), -1));  // Many XOs are invalid
        end
        stallRandom <= 1'b0;
        waitDrained(40);
    endtask

    initial begin
        void'($urandom(32'h9a83));
        repeat (4) @(posedge clock_i);
        rst_i <= 1'b0;
        testLatency();
        testFloat(`PRIM_FLOAT_DOUBLE);
        testFloat(`PRIM_FLOAT_SINGLE);
        testIntSelect();
        testInvalid();
        testStall();
        if (expectedQ.size() != 0) begin
            raiseError("expected outputs were still queued at the end of the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    // Budget of ten cycles per instruction plus margin
    initial begin
        #(CLOCK_PERIOD * (PLANNED_INSTS * CYCLES_PER_INST + MARGIN_CYCLES));
        raiseError("watchdog expired before the tests finished");
    end

endmodule

/* sim.f */
+incdir+source
source/decodePkg.sv
source/stageRegister.sv
source/opcodeDecoder.sv
source/operandClassifier.sv
source/aFormDecoder.sv
testbench/tbAFormDecoder.sv

/* Makefile */
# Verilator flow for the A-form decoder

TB_TOP  = tbAFormDecoder
RTL_TOP = aFormDecoder

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module $(RTL_TOP) -f sim.f

obj_dir/simv: sim.f source/*.sv source/*.svh testbench/*.sv
	verilator --binary --timing --top-module $(TB_TOP) -f sim.f -o simv

sim: obj_dir/simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
